// File: src/vcache_pkg.sv
package vcache_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 10;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // one client request, load or store
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } cache_req_s;

  // store responses carry no useful data
  typedef struct packed {
    data_t data;
  } cache_rsp_s;

  // block-aligned DMA command from a cache
  typedef struct packed {
    logic  write_not_read;
    addr_t addr;
  } dma_pkt_s;

  // index width for n entries, at least one bit
  function automatic int idx_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

// File: src/vr_fifo.sv
`timescale 1ns/1ns

module vr_fifo
  import vcache_pkg::*;
#(
  parameter type payload_t = data_t,
  parameter int fifo_depth_p = 2
) (
  input  logic     core_clk,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  localparam int ptr_w_lp = idx_width(fifo_depth_p);
  localparam int cnt_w_lp = $clog2(fifo_depth_p + 1);

  payload_t mem_r [fifo_depth_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic push;
  logic pop;

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
    return (ptr == ptr_w_lp'(fifo_depth_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o = (count_r != cnt_w_lp'(fifo_depth_p));
  assign out_valid_o = (count_r != '0);
  assign out_data_o = mem_r[rd_ptr_r];
  assign push = in_valid_i && in_ready_o;
  assign pop = out_valid_o && out_ready_i;

  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (push) wr_ptr_r <= next_ptr(wr_ptr_r);
      if (pop) rd_ptr_r <= next_ptr(rd_ptr_r);
      if (push && !pop) count_r <= count_r + 1'b1;
      else if (pop && !push) count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge core_clk) begin
    if (push) mem_r[wr_ptr_r] <= in_data_i;
  end

  assert property (@(posedge core_clk) disable iff (!rst_n_i)
    count_r <= cnt_w_lp'(fifo_depth_p));

endmodule

// File: src/vcache_blocking.sv
`timescale 1ns/1ns

module vcache_blocking
  import vcache_pkg::*;
#(
  parameter int sets_p = 8,
  parameter int block_words_p = 4
) (
  input  logic       core_clk,
  input  logic       rst_n_i,

  input  logic       req_valid_i,
  input  cache_req_s req_i,
  output logic       req_ready_o,
  output logic       rsp_valid_o,
  output cache_rsp_s rsp_o,
  input  logic       rsp_ready_i,

  output logic       dma_pkt_valid_o,
  output dma_pkt_s   dma_pkt_o,
  input  logic       dma_pkt_ready_i,
  output logic       dma_wdata_valid_o,
  output data_t      dma_wdata_o,
  input  logic       dma_wdata_ready_i,
  input  logic       dma_rdata_valid_i,
  input  data_t      dma_rdata_i,
  output logic       dma_rdata_ready_o
);

  localparam int off_w_lp = $clog2(block_words_p);
  localparam int idx_w_lp = $clog2(sets_p);
  localparam int tag_w_lp = ADDR_W - idx_w_lp - off_w_lp;

  typedef enum logic [2:0] {
    S_IDLE,
    S_EVICT_PKT,
    S_EVICT_DATA,
    S_FILL_PKT,
    S_FILL_DATA,
    S_RESPOND
  } state_e;

  state_e state_r;
  cache_req_s req_r;
  cache_req_s cur_req;
  logic [tag_w_lp-1:0] tag_r [sets_p];
  logic [sets_p-1:0] valid_r;
  logic [sets_p-1:0] dirty_r;
  data_t data_r [sets_p][block_words_p];
  data_t rsp_data_r;
  logic [off_w_lp-1:0] beat_r;

  logic [tag_w_lp-1:0] cur_tag;
  logic [idx_w_lp-1:0] cur_idx;
  logic [off_w_lp-1:0] cur_off;
  logic hit;
  logic accept;
  logic last_beat;
  logic evict_fire;
  logic fill_fire;

  // idle looks up the incoming request, the other states the latched one
  assign cur_req = (state_r == S_IDLE) ? req_i : req_r;
  assign {cur_tag, cur_idx, cur_off} = cur_req.addr;
  assign hit = valid_r[cur_idx] && (tag_r[cur_idx] == cur_tag);
  assign accept = req_valid_i && req_ready_o;
  assign last_beat = (beat_r == off_w_lp'(block_words_p - 1));
  assign evict_fire = dma_wdata_valid_o && dma_wdata_ready_i;
  assign fill_fire = dma_rdata_valid_i && dma_rdata_ready_o;

  assign req_ready_o = (state_r == S_IDLE);
  assign rsp_valid_o = (state_r == S_RESPOND);
  assign rsp_o.data = rsp_data_r;

  // eviction uses the resident tag, the fill the requested one
  assign dma_pkt_valid_o = (state_r == S_EVICT_PKT) || (state_r == S_FILL_PKT);
  assign dma_pkt_o.write_not_read = (state_r == S_EVICT_PKT);
  assign dma_pkt_o.addr = {(state_r == S_EVICT_PKT) ? tag_r[cur_idx] : cur_tag,
                           cur_idx, off_w_lp'(0)};
  assign dma_wdata_valid_o = (state_r == S_EVICT_DATA);
  assign dma_wdata_o = data_r[cur_idx][beat_r];
  assign dma_rdata_ready_o = (state_r == S_FILL_DATA);

  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= S_IDLE;
      valid_r <= '0;
      dirty_r <= '0;
      beat_r <= '0;
    end else begin
      case (state_r)
        S_IDLE: begin
          if (accept && hit) begin
            state_r <= S_RESPOND;
            if (req_i.write) dirty_r[cur_idx] <= 1'b1;
          end else if (accept) begin
            state_r <= (valid_r[cur_idx] && dirty_r[cur_idx]) ? S_EVICT_PKT : S_FILL_PKT;
          end
        end
        S_EVICT_PKT: begin
          if (dma_pkt_ready_i) begin
            state_r <= S_EVICT_DATA;
            beat_r <= '0;
          end
        end
        S_EVICT_DATA: begin
          if (evict_fire) begin
            beat_r <= beat_r + 1'b1;
            if (last_beat) state_r <= S_FILL_PKT;
          end
        end
        S_FILL_PKT: begin
          if (dma_pkt_ready_i) begin
            state_r <= S_FILL_DATA;
            beat_r <= '0;
          end
        end
        S_FILL_DATA: begin
          if (fill_fire) begin
            beat_r <= beat_r + 1'b1;
            if (last_beat) begin
              state_r <= S_RESPOND;
              valid_r[cur_idx] <= 1'b1;
              dirty_r[cur_idx] <= req_r.write;
            end
          end
        end
        S_RESPOND: begin
          if (rsp_ready_i) state_r <= S_IDLE;
        end
        default: state_r <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (accept) req_r <= req_i;
    if (accept && hit) begin
      if (req_i.write) data_r[cur_idx][cur_off] <= req_i.wdata;
      else rsp_data_r <= data_r[cur_idx][cur_off];
    end
    // the missing store merges into the refilled block
    if (fill_fire) begin
      if (req_r.write && beat_r == cur_off) data_r[cur_idx][beat_r] <= req_r.wdata;
      else data_r[cur_idx][beat_r] <= dma_rdata_i;
      if (!req_r.write && beat_r == cur_off) rsp_data_r <= dma_rdata_i;
      if (last_beat) tag_r[cur_idx] <= cur_tag;
    end
  end

  // a new request only once the previous response has left
  assert property (@(posedge core_clk) disable iff (!rst_n_i)
    accept |-> $past((state_r == S_IDLE) || (rsp_valid_o && rsp_ready_i)));

endmodule

// File: src/dma_arbiter.sv
`timescale 1ns/1ns

module dma_arbiter
  import vcache_pkg::*;
#(
  parameter int num_caches_p = 2,
  parameter int block_words_p = 4,
  localparam int idx_w_lp = idx_width(num_caches_p)
) (
  input  logic                           core_clk,
  input  logic                           rst_n_i,

  input  logic     [num_caches_p-1:0]    cache_pkt_valid_i,
  input  dma_pkt_s [num_caches_p-1:0]    cache_pkt_i,
  output logic     [num_caches_p-1:0]    cache_pkt_ready_o,
  input  logic     [num_caches_p-1:0]    cache_wdata_valid_i,
  input  data_t    [num_caches_p-1:0]    cache_wdata_i,
  output logic     [num_caches_p-1:0]    cache_wdata_ready_o,
  output logic     [num_caches_p-1:0]    cache_rdata_valid_o,
  output data_t    [num_caches_p-1:0]    cache_rdata_o,
  input  logic     [num_caches_p-1:0]    cache_rdata_ready_i,

  output logic                           mem_pkt_valid_o,
  output logic                           mem_pkt_write_o,
  output logic     [idx_w_lp+ADDR_W-1:0] mem_addr_o,
  input  logic                           mem_pkt_ready_i,
  output logic                           mem_wdata_valid_o,
  output data_t                          mem_wdata_o,
  input  logic                           mem_wdata_ready_i,
  input  logic                           mem_rdata_valid_i,
  input  data_t                          mem_rdata_i,
  output logic                           mem_rdata_ready_o
);

  logic busy_r;
  logic write_r;
  logic [idx_w_lp-1:0] grant_r;
  logic [idx_w_lp-1:0] pick;
  logic [$clog2(block_words_p)-1:0] beat_r;
  logic pkt_fire;
  logic beat_fire;
  logic last_beat;

  // round robin from the cache after the last grant, nearest wins
  always_comb begin
    int unsigned cand;
    pick = grant_r;
    for (int i = num_caches_p; i >= 1; i--) begin
      cand = (int'(grant_r) + i) % num_caches_p;
      if (cache_pkt_valid_i[cand]) pick = idx_w_lp'(cand);
    end
  end

  assign mem_pkt_valid_o = !busy_r && (|cache_pkt_valid_i);
  assign mem_pkt_write_o = cache_pkt_i[pick].write_not_read;
  assign mem_addr_o = {pick, cache_pkt_i[pick].addr};
  assign pkt_fire = mem_pkt_valid_o && mem_pkt_ready_i;

  assign mem_wdata_valid_o = busy_r && write_r && cache_wdata_valid_i[grant_r];
  assign mem_wdata_o = cache_wdata_i[grant_r];
  assign mem_rdata_ready_o = busy_r && !write_r && cache_rdata_ready_i[grant_r];
  assign cache_rdata_o = {num_caches_p{mem_rdata_i}};

  assign beat_fire = write_r ? (mem_wdata_valid_o && mem_wdata_ready_i)
                             : (mem_rdata_valid_i && mem_rdata_ready_o);
  assign last_beat = (beat_r == $bits(beat_r)'(block_words_p - 1));

  always_comb begin
    cache_pkt_ready_o = '0;
    cache_wdata_ready_o = '0;
    cache_rdata_valid_o = '0;
    if (!busy_r) cache_pkt_ready_o[pick] = mem_pkt_ready_i;
    else if (write_r) cache_wdata_ready_o[grant_r] = mem_wdata_ready_i;
    else cache_rdata_valid_o[grant_r] = mem_rdata_valid_i;
  end

  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_r <= 1'b0;
      write_r <= 1'b0;
      grant_r <= idx_w_lp'(num_caches_p - 1);
      beat_r <= '0;
    end else if (pkt_fire) begin
      busy_r <= 1'b1;
      write_r <= mem_pkt_write_o;
      grant_r <= pick;
      beat_r <= '0;
    end else if (busy_r && beat_fire) begin
      beat_r <= beat_r + 1'b1;
      if (last_beat) busy_r <= 1'b0;
    end
  end

  // the channel stays with one cache until its last beat
  assert property (@(posedge core_clk) disable iff (!rst_n_i)
    (busy_r && !(beat_fire && last_beat)) |=> (busy_r && $stable(grant_r)));

endmodule

// File: src/backing_mem.sv
`timescale 1ns/1ns

module backing_mem
  import vcache_pkg::*;
#(
  parameter int num_caches_p = 2,
  parameter int block_words_p = 4,
  localparam int addr_w_lp = idx_width(num_caches_p) + ADDR_W
) (
  input  logic                 core_clk,
  input  logic                 rst_n_i,

  input  logic                 mem_pkt_valid_i,
  input  logic                 mem_pkt_write_i,
  input  logic [addr_w_lp-1:0] mem_addr_i,
  output logic                 mem_pkt_ready_o,
  input  logic                 mem_wdata_valid_i,
  input  data_t                mem_wdata_i,
  output logic                 mem_wdata_ready_o,
  output logic                 mem_rdata_valid_o,
  output data_t                mem_rdata_o,
  input  logic                 mem_rdata_ready_i
);

  data_t mem_r [2**addr_w_lp];
  logic busy_r;
  logic write_r;
  logic [addr_w_lp-1:0] base_r;
  logic [addr_w_lp-1:0] word_addr;
  logic [$clog2(block_words_p)-1:0] beat_r;
  logic pkt_fire;
  logic beat_fire;

  initial begin
    for (int i = 0; i < 2**addr_w_lp; i++) begin
      mem_r[i] = '0;
    end
  end

  assign mem_pkt_ready_o = !busy_r;
  assign pkt_fire = mem_pkt_valid_i && mem_pkt_ready_o;
  assign word_addr = base_r + addr_w_lp'(beat_r);

  assign mem_wdata_ready_o = busy_r && write_r;
  assign mem_rdata_valid_o = busy_r && !write_r;
  assign mem_rdata_o = mem_r[word_addr];
  assign beat_fire = (mem_wdata_valid_i && mem_wdata_ready_o)
                  || (mem_rdata_valid_o && mem_rdata_ready_i);

  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_r <= 1'b0;
      write_r <= 1'b0;
      beat_r <= '0;
    end else if (pkt_fire) begin
      busy_r <= 1'b1;
      write_r <= mem_pkt_write_i;
      beat_r <= '0;
    end else if (beat_fire) begin
      beat_r <= beat_r + 1'b1;
      if (beat_r == $bits(beat_r)'(block_words_p - 1)) busy_r <= 1'b0;
    end
  end

  always_ff @(posedge core_clk) begin
    if (pkt_fire) base_r <= mem_addr_i;
  end

  always @(posedge core_clk) begin
    if (mem_wdata_valid_i && mem_wdata_ready_o) mem_r[word_addr] <= mem_wdata_i;
  end

endmodule

// File: src/mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top
  import vcache_pkg::*;
#(
  parameter int num_caches_p = 2,
  parameter int sets_p = 8,
  parameter int block_words_p = 4,
  parameter int fifo_depth_p = 2
) (
  input  logic                          core_clk,
  input  logic                          rst_n_i,
  input  logic       [num_caches_p-1:0] req_valid_i,
  input  cache_req_s [num_caches_p-1:0] req_i,
  output logic       [num_caches_p-1:0] req_ready_o,
  output logic       [num_caches_p-1:0] rsp_valid_o,
  output cache_rsp_s [num_caches_p-1:0] rsp_o,
  input  logic       [num_caches_p-1:0] rsp_ready_i
);

  localparam int addr_w_lp = idx_width(num_caches_p) + ADDR_W;

  // fifo to cache and cache to fifo
  logic       [num_caches_p-1:0] creq_valid;
  logic       [num_caches_p-1:0] creq_ready;
  cache_req_s [num_caches_p-1:0] creq;
  logic       [num_caches_p-1:0] crsp_valid;
  logic       [num_caches_p-1:0] crsp_ready;
  cache_rsp_s [num_caches_p-1:0] crsp;

  logic     [num_caches_p-1:0] dma_pkt_valid;
  logic     [num_caches_p-1:0] dma_pkt_ready;
  dma_pkt_s [num_caches_p-1:0] dma_pkt;
  logic     [num_caches_p-1:0] dma_wdata_valid;
  logic     [num_caches_p-1:0] dma_wdata_ready;
  data_t    [num_caches_p-1:0] dma_wdata;
  logic     [num_caches_p-1:0] dma_rdata_valid;
  logic     [num_caches_p-1:0] dma_rdata_ready;
  data_t    [num_caches_p-1:0] dma_rdata;

  logic                 mem_pkt_valid;
  logic                 mem_pkt_write;
  logic [addr_w_lp-1:0] mem_addr;
  logic                 mem_pkt_ready;
  logic                 mem_wdata_valid;
  data_t                mem_wdata;
  logic                 mem_wdata_ready;
  logic                 mem_rdata_valid;
  data_t                mem_rdata;
  logic                 mem_rdata_ready;

  for (genvar i = 0; i < num_caches_p; i++) begin : port

    vr_fifo #(
      .payload_t(cache_req_s)
      ,.fifo_depth_p(fifo_depth_p)
    ) req_fifo (
      .core_clk(core_clk)
      ,.rst_n_i(rst_n_i)
      ,.in_valid_i(req_valid_i[i])
      ,.in_data_i(req_i[i])
      ,.in_ready_o(req_ready_o[i])
      ,.out_valid_o(creq_valid[i])
      ,.out_data_o(creq[i])
      ,.out_ready_i(creq_ready[i])
    );

    vcache_blocking #(
      .sets_p(sets_p)
      ,.block_words_p(block_words_p)
    ) vcache (
      .core_clk(core_clk)
      ,.rst_n_i(rst_n_i)
      ,.req_valid_i(creq_valid[i])
      ,.req_i(creq[i])
      ,.req_ready_o(creq_ready[i])
      ,.rsp_valid_o(crsp_valid[i])
      ,.rsp_o(crsp[i])
      ,.rsp_ready_i(crsp_ready[i])
      ,.dma_pkt_valid_o(dma_pkt_valid[i])
      ,.dma_pkt_o(dma_pkt[i])
      ,.dma_pkt_ready_i(dma_pkt_ready[i])
      ,.dma_wdata_valid_o(dma_wdata_valid[i])
      ,.dma_wdata_o(dma_wdata[i])
      ,.dma_wdata_ready_i(dma_wdata_ready[i])
      ,.dma_rdata_valid_i(dma_rdata_valid[i])
      ,.dma_rdata_i(dma_rdata[i])
      ,.dma_rdata_ready_o(dma_rdata_ready[i])
    );

    vr_fifo #(
      .payload_t(cache_rsp_s)
      ,.fifo_depth_p(fifo_depth_p)
    ) rsp_fifo (
      .core_clk(core_clk)
      ,.rst_n_i(rst_n_i)
      ,.in_valid_i(crsp_valid[i])
      ,.in_data_i(crsp[i])
      ,.in_ready_o(crsp_ready[i])
      ,.out_valid_o(rsp_valid_o[i])
      ,.out_data_o(rsp_o[i])
      ,.out_ready_i(rsp_ready_i[i])
    );
  end

  dma_arbiter #(
    .num_caches_p(num_caches_p)
    ,.block_words_p(block_words_p)
  ) arb (
    .core_clk(core_clk)
    ,.rst_n_i(rst_n_i)
    ,.cache_pkt_valid_i(dma_pkt_valid)
    ,.cache_pkt_i(dma_pkt)
    ,.cache_pkt_ready_o(dma_pkt_ready)
    ,.cache_wdata_valid_i(dma_wdata_valid)
    ,.cache_wdata_i(dma_wdata)
    ,.cache_wdata_ready_o(dma_wdata_ready)
    ,.cache_rdata_valid_o(dma_rdata_valid)
    ,.cache_rdata_o(dma_rdata)
    ,.cache_rdata_ready_i(dma_rdata_ready)
    ,.mem_pkt_valid_o(mem_pkt_valid)
    ,.mem_pkt_write_o(mem_pkt_write)
    ,.mem_addr_o(mem_addr)
    ,.mem_pkt_ready_i(mem_pkt_ready)
    ,.mem_wdata_valid_o(mem_wdata_valid)
    ,.mem_wdata_o(mem_wdata)
    ,.mem_wdata_ready_i(mem_wdata_ready)
    ,.mem_rdata_valid_i(mem_rdata_valid)
    ,.mem_rdata_i(mem_rdata)
    ,.mem_rdata_ready_o(mem_rdata_ready)
  );

  backing_mem #(
    .num_caches_p(num_caches_p)
    ,.block_words_p(block_words_p)
  ) mem (
    .core_clk(core_clk)
    ,.rst_n_i(rst_n_i)
    ,.mem_pkt_valid_i(mem_pkt_valid)
    ,.mem_pkt_write_i(mem_pkt_write)
    ,.mem_addr_i(mem_addr)
    ,.mem_pkt_ready_o(mem_pkt_ready)
    ,.mem_wdata_valid_i(mem_wdata_valid)
    ,.mem_wdata_i(mem_wdata)
    ,.mem_wdata_ready_o(mem_wdata_ready)
    ,.mem_rdata_valid_o(mem_rdata_valid)
    ,.mem_rdata_o(mem_rdata)
    ,.mem_rdata_ready_i(mem_rdata_ready)
  );

endmodule

// File: bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// one expected response, store data is ignored
typedef struct packed {
  logic  is_store;
  data_t data;
} exp_rsp_s;

// one word array per port, each port sees only its own region
data_t ref_mem [num_ports_lp][2**ADDR_W];
exp_rsp_s exp_q [num_ports_lp][$];

initial begin
  for (int p = 0; p < num_ports_lp; p++) begin
    for (int a = 0; a < 2**ADDR_W; a++) begin
      ref_mem[p][a] = '0;
    end
  end
end

// a load returns the last value stored to the same port and address
function automatic data_t ref_load_value(input int port, input addr_t addr);
  return ref_mem[port][addr];
endfunction

task automatic ref_record_request(input int port, input cache_req_s req);
  exp_rsp_s expected;
  expected.is_store = req.write;
  expected.data = req.write ? '0 : ref_load_value(port, req.addr);
  if (req.write) ref_mem[port][req.addr] = req.wdata;
  exp_q[port].push_back(expected);
endtask

task automatic stop_with_failure();
  $display("Done: errors found");
  $fatal(1);
endtask

task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] expected);
  if (got !== expected) begin
    $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, expected);
    stop_with_failure();
  end
endtask

`endif

// File: bench/tb_mem_subsys.sv
`timescale 1ns/1ns

module tb_mem_subsys
  import vcache_pkg::*;
();

  localparam int num_ports_lp = 2;
  localparam int sets_lp = 8;
  localparam int block_words_lp = 4;
  localparam int fifo_depth_lp = 2;
  localparam int clk_period_lp = 10;
  localparam int reset_cycles_lp = 4;
  localparam int directed_reqs_lp = 18;
  localparam int random_per_port_lp = 300;
  localparam int random_span_lp = 128;
  // covers eviction, refill, the other port's traffic and stalls
  localparam int cycles_per_req_lp = 80;
  localparam longint timeout_ns_lp = longint'(directed_reqs_lp
    + num_ports_lp * random_per_port_lp) * cycles_per_req_lp * clk_period_lp;

  logic core_clk = 1'b0;
  logic rst_n_i = 1'b0;
  logic       [num_ports_lp-1:0] req_valid_i = '0;
  cache_req_s [num_ports_lp-1:0] req_i = '0;
  logic       [num_ports_lp-1:0] req_ready_o;
  logic       [num_ports_lp-1:0] rsp_valid_o;
  cache_rsp_s [num_ports_lp-1:0] rsp_o;
  logic       [num_ports_lp-1:0] rsp_ready_i = '1;
  logic backpressure_on = 1'b0;

  cache_req_s stim_q [num_ports_lp][$];

`include "tb_ref_model.svh"

  mem_subsys_top #(
    .num_caches_p(num_ports_lp)
    ,.sets_p(sets_lp)
    ,.block_words_p(block_words_lp)
    ,.fifo_depth_p(fifo_depth_lp)
  ) dut0 (
    .core_clk(core_clk)
    ,.rst_n_i(rst_n_i)
    ,.req_valid_i(req_valid_i)
    ,.req_i(req_i)
    ,.req_ready_o(req_ready_o)
    ,.rsp_valid_o(rsp_valid_o)
    ,.rsp_o(rsp_o)
    ,.rsp_ready_i(rsp_ready_i)
  );

  always #(clk_period_lp / 2) core_clk = ~core_clk;

  function automatic int outstanding();
    int n;
    n = 0;
    for (int p = 0; p < num_ports_lp; p++) begin
      n += stim_q[p].size() + exp_q[p].size();
    end
    return n;
  endfunction

  task automatic push_request(input int port, input logic write, input addr_t addr,
                              input data_t wdata);
    cache_req_s req;
    req.write = write;
    req.addr = addr;
    req.wdata = wdata;
    stim_q[port].push_back(req);
  endtask

  task automatic drain();
    while (outstanding() != 0) @(posedge core_clk);
  endtask

  // request driver, head of each queue is what the port presents
  always @(posedge core_clk) begin
    for (int p = 0; p < num_ports_lp; p++) begin
      if (req_valid_i[p] && req_ready_o[p]) begin
        ref_record_request(p, req_i[p]);
        stim_q[p].delete(0);
      end
      if (!(req_valid_i[p] && !req_ready_o[p])) begin
        if (stim_q[p].size() != 0 && (!backpressure_on || $urandom % 4 != 0)) begin
          req_valid_i[p] <= 1'b1;
          req_i[p] <= stim_q[p][0];
        end else begin
          req_valid_i[p] <= 1'b0;
        end
      end
      rsp_ready_i[p] <= backpressure_on ? ($urandom % 3 != 0) : 1'b1;
    end
  end

  // response checker
  always @(posedge core_clk) begin
    exp_rsp_s expected;
    for (int p = 0; p < num_ports_lp; p++) begin
      if (rst_n_i && rsp_valid_o[p] && rsp_ready_i[p]) begin
        if (exp_q[p].size() == 0) begin
          $display("ERROR: port %0d gave a response with no request outstanding at %0t",
                   p, $time);
          stop_with_failure();
        end else begin
          expected = exp_q[p].pop_front();
          if (!expected.is_store) begin
            check_value($sformatf("rsp_o[%0d]", p), rsp_o[p].data, expected.data);
          end
        end
      end
    end
  end

  initial begin
    #(timeout_ns_lp);
    $display("ERROR: watchdog expired at %0t with %0d requests or responses outstanding",
             $time, outstanding());
    stop_with_failure();
  end

  initial begin
    addr_t addr_a;
    addr_t addr_b;
    void'($urandom(32'h2a94));
    repeat (reset_cycles_lp) @(posedge core_clk);
    rst_n_i <= 1'b1;
    @(posedge core_clk);
    check_value("rsp_valid_o", DATA_W'(rsp_valid_o), '0);
    check_value("req_ready_o", DATA_W'(req_ready_o), DATA_W'({num_ports_lp{1'b1}}));

    // loads from untouched memory
    push_request(0, 1'b0, 10'h010, '0);
    push_request(1, 1'b0, 10'h3f0, '0);
    drain();

    push_request(0, 1'b1, 10'h024, 32'hcafe_0001);
    push_request(0, 1'b0, 10'h024, '0);
    push_request(1, 1'b1, 10'h101, 32'h1234_5678);
    push_request(1, 1'b0, 10'h101, '0);
    drain();

    // B lands in A's set with another tag, so A gets evicted and refilled
    for (int p = 0; p < num_ports_lp; p++) begin
      addr_a = (p == 0) ? 10'h045 : 10'h2ca;
      addr_b = addr_a + addr_t'(sets_lp * block_words_lp);
      push_request(p, 1'b1, addr_a, 32'ha000_0000 + p);
      push_request(p, 1'b1, addr_b, 32'hb000_0000 + p);
      push_request(p, 1'b0, addr_a, '0);
      push_request(p, 1'b0, addr_b, '0);
    end
    drain();

    push_request(0, 1'b1, 10'h0c7, 32'h0000_1111);
    push_request(1, 1'b1, 10'h0c7, 32'h0000_2222);
    push_request(0, 1'b0, 10'h0c7, '0);
    push_request(1, 1'b0, 10'h0c7, '0);
    drain();

    backpressure_on <= 1'b1;
    for (int i = 0; i < random_per_port_lp; i++) begin
      for (int p = 0; p < num_ports_lp; p++) begin
        push_request(p, 1'($urandom % 2), addr_t'($urandom % random_span_lp), $urandom);
      end
    end
    drain();
    backpressure_on <= 1'b0;

    // give a stray extra response time to show up
    repeat (20) @(posedge core_clk);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: list.f
+incdir+bench
src/vcache_pkg.sv
src/vr_fifo.sv
src/vcache_blocking.sv
src/dma_arbiter.sv
src/backing_mem.sv
src/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tb_mem_subsys
FILELIST := list.f
OBJ_DIR  := obj_dir
PASS_MSG := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the simulation printed the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
